// ==== compile.f ====
ld_pkg.sv
load_req_ctrl.sv
load_buffer.sv
load_result_align.sv
load_unit.sv
tb_load_unit_sva.sv
tb_load_unit.sv

// ==== ld_pkg.sv ====
// ---------------------------------------------------------------------------
// load unit package: widths, load ops, controller states and the
// request, cache and load buffer structs shared by all blocks
// ---------------------------------------------------------------------------
`default_nettype none

package ld_pkg;

  // data path width and the number of byte offset bits within one word
  localparam int unsigned XLEN             = 64;
  localparam int unsigned XLEN_ALIGN_BYTES = 3;

  // scoreboard id carried along with every load
  localparam int unsigned TRANS_ID_BITS = 3;

  // cache address split, the index is untranslated
  localparam int unsigned DCACHE_INDEX_WIDTH = 12;
  localparam int unsigned DCACHE_TAG_WIDTH   = 20;
  localparam int unsigned VADDR_WIDTH        = 32;
  localparam int unsigned PADDR_WIDTH        = 32;

  // cache request and response id, which bounds the load buffer at 16 entries
  localparam int unsigned DCACHE_ID_WIDTH = 4;

  // kind of load, selects the transfer size and the extension
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } load_op_e;

  // load request controller states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    WAIT_FLUSH
  } ld_state_e;

  // load as presented by the issue stage
  typedef struct packed {
    logic [VADDR_WIDTH-1:0]   vaddr;
    logic [TRANS_ID_BITS-1:0] trans_id;
    load_op_e                 operation;
    logic [XLEN/8-1:0]        be;
  } ld_req_t;

  // request towards the data cache, index first and tag one cycle later
  typedef struct packed {
    logic [DCACHE_INDEX_WIDTH-1:0] address_index;
    logic [DCACHE_TAG_WIDTH-1:0]   address_tag;
    logic                          data_req;
    logic [1:0]                    data_size;
    logic [XLEN/8-1:0]             data_be;
    logic [DCACHE_ID_WIDTH-1:0]    data_id;
    logic                          kill_req;
    logic                          tag_valid;
  } dcache_req_t;

  // grant and out of order response from the data cache
  typedef struct packed {
    logic                       data_gnt;
    logic                       data_rvalid;
    logic [DCACHE_ID_WIDTH-1:0] data_rid;
    logic [XLEN-1:0]            data_rdata;
  } dcache_rsp_t;

  // one outstanding load, enough to retire and align its response
  typedef struct packed {
    logic [TRANS_ID_BITS-1:0]    trans_id;
    logic [XLEN_ALIGN_BYTES-1:0] address_offset;
    load_op_e                    operation;
  } ldbuf_entry_t;

endpackage

`default_nettype wire

// ==== load_buffer.sv ====
// ---------------------------------------------------------------------------
// load buffer: tracks outstanding loads by cache request id and retires
// their responses in any order
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_buffer #(
  parameter int unsigned NR_LDBUF_ENTRIES = 4
) (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                flush_i,
  input  wire ld_pkg::ld_req_t                     ld_req_i,
  input  wire ld_pkg::dcache_req_t                 dcache_req_i,
  input  wire ld_pkg::dcache_rsp_t                 dcache_rsp_i,
  output logic                                     ldbuf_full_o,
  output logic [ld_pkg::DCACHE_ID_WIDTH-1:0]       ldbuf_free_id_o,
  output ld_pkg::ldbuf_entry_t                     rsp_entry_o,
  output logic                                     valid_o,
  output logic [ld_pkg::TRANS_ID_BITS-1:0]         trans_id_o
);

  localparam int unsigned ID_BITS = $clog2(NR_LDBUF_ENTRIES);

  // the request id has to address every slot, and a single slot is not supported
  if (NR_LDBUF_ENTRIES < 2 || ID_BITS > ld_pkg::DCACHE_ID_WIDTH) begin : gen_depth_check
    $error("load buffer depth must be between 2 and 2**DCACHE_ID_WIDTH");
  end

  ld_pkg::ldbuf_entry_t [NR_LDBUF_ENTRIES-1:0] entries_q;
  logic [NR_LDBUF_ENTRIES-1:0] valid_q, valid_d;
  logic [NR_LDBUF_ENTRIES-1:0] flushed_q, flushed_d;
  logic [ID_BITS-1:0]          free_idx;
  logic [ID_BITS-1:0]          rd_idx;
  logic [ID_BITS-1:0]          last_id_q;
  logic                        wr_en;
  logic                        tag_pending_q;
  logic                        kill_last;

  assign ldbuf_full_o    = &valid_q;
  assign ldbuf_free_id_o = ld_pkg::DCACHE_ID_WIDTH'(free_idx);

  // lowest free slot, scanning down so the smallest index wins
  always_comb begin
    free_idx = '0;
    for (int i = NR_LDBUF_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = ID_BITS'(i);
      end
    end
  end

  // an entry is allocated on every granted index request
  assign wr_en  = dcache_req_i.data_req && dcache_rsp_i.data_gnt;
  assign rd_idx = dcache_rsp_i.data_rid[ID_BITS-1:0];

  // a kill in the cycle after a grant cancels that request, the cache
  // never answers it so the slot is released here
  assign kill_last = dcache_req_i.kill_req && dcache_req_i.tag_valid && tag_pending_q;

  // ---------------------------------------------------------------------------
  // flag update
  // ---------------------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight at a flush is dropped on return
    if (flush_i) begin
      flushed_d = flushed_q | valid_q;
    end
    if (dcache_rsp_i.data_rvalid) begin
      valid_d[rd_idx] = 1'b0;
    end
    if (kill_last) begin
      valid_d[last_id_q] = 1'b0;
    end
    if (wr_en) begin
      valid_d[free_idx]   = 1'b1;
      flushed_d[free_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q       <= '0;
      flushed_q     <= '0;
      last_id_q     <= '0;
      tag_pending_q <= 1'b0;
    end else begin
      valid_q       <= valid_d;
      flushed_q     <= flushed_d;
      tag_pending_q <= wr_en;
      if (wr_en) begin
        last_id_q <= free_idx;
      end
    end
  end

  // entry payload, only meaningful while its valid flag is set
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      entries_q[free_idx].trans_id       <= ld_req_i.trans_id;
      entries_q[free_idx].address_offset <= ld_req_i.vaddr[ld_pkg::XLEN_ALIGN_BYTES-1:0];
      entries_q[free_idx].operation      <= ld_req_i.operation;
    end
  end

  // ---------------------------------------------------------------------------
  // response lookup
  // ---------------------------------------------------------------------------
  assign rsp_entry_o = entries_q[rd_idx];
  assign trans_id_o  = entries_q[rd_idx].trans_id;

  // suppress flushed loads and the newest load while its tag is being killed
  assign valid_o = dcache_rsp_i.data_rvalid && !flushed_q[rd_idx] &&
                   ((last_id_q != rd_idx) || !dcache_req_i.kill_req);

endmodule

`default_nettype wire

// ==== load_req_ctrl.sv ====
// ---------------------------------------------------------------------------
// load request controller: sends index and tag to the data cache and pops
// the accepted load from the issue stage
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_req_ctrl (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  input  wire logic                               flush_i,
  input  wire logic                               valid_i,
  input  wire ld_pkg::ld_req_t                    ld_req_i,
  input  wire logic [ld_pkg::PADDR_WIDTH-1:0]     paddr_i,
  input  wire logic                               page_offset_matches_i,
  input  wire ld_pkg::dcache_rsp_t                dcache_rsp_i,
  input  wire logic                               ldbuf_full_i,
  input  wire logic [ld_pkg::DCACHE_ID_WIDTH-1:0] ldbuf_free_id_i,
  output logic                                    pop_ld_o,
  output logic [11:0]                             page_offset_o,
  output ld_pkg::dcache_req_t                     dcache_req_o
);

  ld_pkg::ld_state_e state_q, state_d;
  logic              accept_req;

  // log2 of the byte count of the access
  function automatic logic [1:0] transfer_size(ld_pkg::load_op_e op);
    case (op)
      ld_pkg::LW, ld_pkg::LWU: transfer_size = 2'd2;
      ld_pkg::LH, ld_pkg::LHU: transfer_size = 2'd1;
      ld_pkg::LB, ld_pkg::LBU: transfer_size = 2'd0;
      default:                 transfer_size = 2'd3;
    endcase
  endfunction

  // the store side compares the untranslated page offset
  assign page_offset_o = ld_req_i.vaddr[11:0];

  // a new load is only taken while the buffer has a free slot
  assign accept_req = valid_i && !ldbuf_full_i;

  // ---------------------------------------------------------------------------
  // request FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    pop_ld_o = 1'b0;

    // index and tag fields follow the request, the FSM only drives strobes
    dcache_req_o.address_index = ld_req_i.vaddr[ld_pkg::DCACHE_INDEX_WIDTH-1:0];
    dcache_req_o.address_tag   =
      paddr_i[ld_pkg::DCACHE_TAG_WIDTH+ld_pkg::DCACHE_INDEX_WIDTH-1:ld_pkg::DCACHE_INDEX_WIDTH];
    dcache_req_o.data_size     = transfer_size(ld_req_i.operation);
    dcache_req_o.data_be       = ld_req_i.be;
    dcache_req_o.data_id       = ldbuf_free_id_i;
    dcache_req_o.data_req      = 1'b0;
    dcache_req_o.kill_req      = 1'b0;
    dcache_req_o.tag_valid     = 1'b0;

    case (state_q)
      // SEND_TAG presents the tag of the previous load and may already
      // start the next one, so both states share the accept path
      ld_pkg::IDLE, ld_pkg::SEND_TAG: begin
        if (state_q == ld_pkg::SEND_TAG) begin
          dcache_req_o.tag_valid = 1'b1;
          state_d = ld_pkg::IDLE;
        end
        if (accept_req) begin
          if (page_offset_matches_i) begin
            // a pending store hits the same page offset, hold the load back
            state_d = ld_pkg::WAIT_PAGE_OFFSET;
          end else begin
            dcache_req_o.data_req = 1'b1;
            if (dcache_rsp_i.data_gnt) begin
              pop_ld_o = 1'b1;
              state_d  = ld_pkg::SEND_TAG;
            end else begin
              state_d = ld_pkg::WAIT_GNT;
            end
          end
        end
      end

      // the store has to drain before the index goes out
      ld_pkg::WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = ld_pkg::WAIT_GNT;
        end
      end

      // keep the request up until the cache grants it
      ld_pkg::WAIT_GNT: begin
        dcache_req_o.data_req = 1'b1;
        if (dcache_rsp_i.data_gnt) begin
          pop_ld_o = 1'b1;
          state_d  = ld_pkg::SEND_TAG;
        end
      end

      // cancel whatever tag is due this cycle, then start over
      ld_pkg::WAIT_FLUSH: begin
        dcache_req_o.kill_req  = 1'b1;
        dcache_req_o.tag_valid = 1'b1;
        state_d = ld_pkg::IDLE;
      end

      default: begin
        state_d = ld_pkg::IDLE;
      end
    endcase

    // a flush wins over every other transition
    if (flush_i) begin
      state_d = ld_pkg::WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ld_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// ==== load_result_align.sv ====
// ---------------------------------------------------------------------------
// load result aligner: moves the loaded field to bit 0 and extends it
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_result_align (
  input  wire ld_pkg::ldbuf_entry_t      rsp_entry_i,
  input  wire logic [ld_pkg::XLEN-1:0]   rdata_i,
  output logic [ld_pkg::XLEN-1:0]        result_o
);

  logic [ld_pkg::XLEN-1:0]             shifted;
  logic [ld_pkg::XLEN/8-1:0]           byte_msbs;
  logic [ld_pkg::XLEN_ALIGN_BYTES-1:0] sign_byte;
  logic                                is_signed;
  logic                                sign_bit;

  // byte offset times eight gives the bit shift
  assign shifted = rdata_i >> {rsp_entry_i.address_offset, 3'b000};

  // top bit of every byte, the sign is picked from these in parallel
  // to the shifter instead of after it
  always_comb begin
    for (int i = 0; i < ld_pkg::XLEN / 8; i++) begin
      byte_msbs[i] = rdata_i[i*8+7];
    end
  end

  assign is_signed = rsp_entry_i.operation inside {ld_pkg::LW, ld_pkg::LH, ld_pkg::LB};

  // the sign sits in the last byte of the loaded field
  always_comb begin
    case (rsp_entry_i.operation)
      ld_pkg::LW, ld_pkg::LWU: sign_byte = rsp_entry_i.address_offset + 3'd3;
      ld_pkg::LH, ld_pkg::LHU: sign_byte = rsp_entry_i.address_offset + 3'd1;
      default:                 sign_byte = rsp_entry_i.address_offset;
    endcase
  end

  // unsigned loads fill with zeros
  assign sign_bit = is_signed && byte_msbs[sign_byte];

  always_comb begin
    case (rsp_entry_i.operation)
      ld_pkg::LW, ld_pkg::LWU: result_o = {{ld_pkg::XLEN-32{sign_bit}}, shifted[31:0]};
      ld_pkg::LH, ld_pkg::LHU: result_o = {{ld_pkg::XLEN-16{sign_bit}}, shifted[15:0]};
      ld_pkg::LB, ld_pkg::LBU: result_o = {{ld_pkg::XLEN-8{sign_bit}}, shifted[7:0]};
      // LD takes the full word
      default:                 result_o = shifted;
    endcase
  end

endmodule

`default_nettype wire

// ==== load_unit.sv ====
// ---------------------------------------------------------------------------
// load unit: load path of the LSU with several loads outstanding in the cache
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_unit #(
  parameter int unsigned NR_LDBUF_ENTRIES = 4
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  input  wire logic                           valid_i,
  input  wire ld_pkg::ld_req_t                ld_req_i,
  input  wire logic [ld_pkg::PADDR_WIDTH-1:0] paddr_i,
  input  wire logic                           page_offset_matches_i,
  input  wire ld_pkg::dcache_rsp_t            dcache_rsp_i,
  output logic                                pop_ld_o,
  output logic [11:0]                         page_offset_o,
  output ld_pkg::dcache_req_t                 dcache_req_o,
  output logic                                valid_o,
  output logic [ld_pkg::TRANS_ID_BITS-1:0]    trans_id_o,
  output logic [ld_pkg::XLEN-1:0]             result_o
);

  logic                               ldbuf_full;
  logic [ld_pkg::DCACHE_ID_WIDTH-1:0] ldbuf_free_id;
  ld_pkg::ldbuf_entry_t               rsp_entry;

  // request side, the buffer supplies the request id and back-pressure
  load_req_ctrl u_req_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .ld_req_i              (ld_req_i),
    .paddr_i               (paddr_i),
    .page_offset_matches_i (page_offset_matches_i),
    .dcache_rsp_i          (dcache_rsp_i),
    .ldbuf_full_i          (ldbuf_full),
    .ldbuf_free_id_i       (ldbuf_free_id),
    .pop_ld_o              (pop_ld_o),
    .page_offset_o         (page_offset_o),
    .dcache_req_o          (dcache_req_o)
  );

  // outstanding loads, snooping the cache request and response
  load_buffer #(
    .NR_LDBUF_ENTRIES (NR_LDBUF_ENTRIES)
  ) u_load_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .ld_req_i        (ld_req_i),
    .dcache_req_i    (dcache_req_o),
    .dcache_rsp_i    (dcache_rsp_i),
    .ldbuf_full_o    (ldbuf_full),
    .ldbuf_free_id_o (ldbuf_free_id),
    .rsp_entry_o     (rsp_entry),
    .valid_o         (valid_o),
    .trans_id_o      (trans_id_o)
  );

  // response data formatting
  load_result_align u_result_align (
    .rsp_entry_i (rsp_entry),
    .rdata_i     (dcache_rsp_i.data_rdata),
    .result_o    (result_o)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the load unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_load_unit
./obj_dir/Vtb_load_unit

// ==== tb_load_unit.sv ====
// ---------------------------------------------------------------------------
// load unit testbench: directed loads against an out of order cache model
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_load_unit;

  localparam int NUM_TESTS = 5;

  typedef struct packed {
    logic [3:0]  id;
    logic [11:0] index;
    logic [19:0] tag;
  } pend_t;

  logic clk_i, rst_ni, flush_i, valid_i, page_offset_matches_i;
  ld_pkg::ld_req_t     ld_req;
  logic [31:0]         paddr;
  ld_pkg::dcache_rsp_t dcache_rsp;
  ld_pkg::dcache_req_t dcache_req;
  logic                pop_ld, valid_o;
  logic [11:0]         page_offset;
  logic [2:0]          trans_id;
  logic [63:0]         result;

  integer seed = 32'hb94d_1189;
  string  test_name = "reset";
  int     error_count = 0;

  // cache model state, written by the model at the sample point only
  pend_t            pending[$];
  pend_t            cur;
  int               gnt_delay = 0;
  int               rsp_delay = 0;
  int               force_delay = 0;
  bit               hold_rsp = 0;
  bit               reverse_rsp = 0;
  bit               tag_due = 0;
  pend_t            last_req;
  int               num_outstanding = 0;

  // scoreboard indexed by cache request id
  logic [2:0]        exp_tid[16];
  logic [2:0]        exp_off[16];
  ld_pkg::load_op_e  exp_op[16];
  bit                exp_flushed[16];
  bit                outstanding[16];

  load_unit #(.NR_LDBUF_ENTRIES(4)) u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .valid_i(valid_i),
    .ld_req_i(ld_req), .paddr_i(paddr), .page_offset_matches_i(page_offset_matches_i),
    .dcache_rsp_i(dcache_rsp), .pop_ld_o(pop_ld), .page_offset_o(page_offset),
    .dcache_req_o(dcache_req), .valid_o(valid_o), .trans_id_o(trans_id), .result_o(result)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // reference rules
  // --------------------------------------------------------------------------
  // byte k is the low byte of (tag + index) xor k times 3b
  function automatic logic [63:0] pattern_data(logic [11:0] index, logic [19:0] tag);
    logic [19:0] sum;
    logic [31:0] prod;
    logic [63:0] d;
    sum = tag + {8'h00, index};
    for (int k = 0; k < 8; k++) begin
      prod = k * 32'h3b;
      d[k*8 +: 8] = sum[7:0] ^ prod[7:0];
    end
    return d;
  endfunction

  // shift by the byte offset, then sign or zero extend the loaded field
  function automatic logic [63:0] expected_result(ld_pkg::load_op_e op, logic [2:0] off,
                                                  logic [63:0] data);
    logic [63:0] f;
    f = data >> (8 * int'(off));
    case (op)
      ld_pkg::LW:  return {{32{f[31]}}, f[31:0]};
      ld_pkg::LWU: return {32'h0, f[31:0]};
      ld_pkg::LH:  return {{48{f[15]}}, f[15:0]};
      ld_pkg::LHU: return {48'h0, f[15:0]};
      ld_pkg::LB:  return {{56{f[7]}}, f[7:0]};
      ld_pkg::LBU: return {56'h0, f[7:0]};
      default:     return f;
    endcase
  endfunction

  // log2 of the number of bytes that the op reads
  function automatic logic [1:0] access_size(ld_pkg::load_op_e op);
    case (op)
      ld_pkg::LD:              return 2'd3;
      ld_pkg::LW, ld_pkg::LWU: return 2'd2;
      ld_pkg::LH, ld_pkg::LHU: return 2'd1;
      default:                 return 2'd0;
    endcase
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      error_count++;
      $display("** Error [%s] %s: expected %h actual %h", test_name, what, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  // --------------------------------------------------------------------------
  // cache model, drives on the falling edge and samples 10 ns before rising
  // --------------------------------------------------------------------------
  initial begin : cache_model
    forever begin
      @(negedge clk_i);
      if (force_delay > 0) begin
        gnt_delay = force_delay;
        force_delay = 0;
      end
      dcache_rsp.data_gnt    = (gnt_delay == 0);
      dcache_rsp.data_rvalid = 1'b0;
      if (!hold_rsp && pending.size() > 0) begin
        if (rsp_delay == 0) begin
          // reversed order returns the newest request first
          if (reverse_rsp) cur = pending.pop_back();
          else cur = pending.pop_front();
          dcache_rsp.data_rvalid = 1'b1;
          dcache_rsp.data_rid    = cur.id;
          dcache_rsp.data_rdata  = pattern_data(cur.index, cur.tag);
          rsp_delay = {$random(seed)} % 3;
        end else begin
          rsp_delay--;
        end
      end
      #40;
      if (rst_ni) begin
        if (dcache_rsp.data_rvalid) begin
          cur.id = dcache_rsp.data_rid;
          check("valid_o", 64'(!exp_flushed[cur.id]), 64'(valid_o));
          if (!exp_flushed[cur.id]) begin
            check("trans_id_o", 64'(exp_tid[cur.id]), 64'(trans_id));
            check("result_o", expected_result(exp_op[cur.id], exp_off[cur.id],
                  dcache_rsp.data_rdata), result);
          end
          outstanding[cur.id] = 1'b0;
          num_outstanding--;
        end
        if (tag_due) begin
          tag_due = 0;
          check("tag_valid", 64'(1), 64'(dcache_req.tag_valid));
          if (dcache_req.kill_req) begin
            // a killed request gets no response
            outstanding[last_req.id] = 1'b0;
            num_outstanding--;
          end else begin
            last_req.tag = dcache_req.address_tag;
            pending.push_back(last_req);
          end
        end
        if (flush_i) begin
          for (int i = 0; i < 16; i++) begin
            if (outstanding[i]) exp_flushed[i] = 1'b1;
          end
        end
        if (dcache_req.data_req && dcache_rsp.data_gnt) begin
          last_req.id    = dcache_req.data_id;
          last_req.index = dcache_req.address_index;
          exp_tid[last_req.id]     = ld_req.trans_id;
          exp_off[last_req.id]     = ld_req.vaddr[2:0];
          exp_op[last_req.id]      = ld_req.operation;
          exp_flushed[last_req.id] = 1'b0;
          outstanding[last_req.id] = 1'b1;
          num_outstanding++;
          tag_due   = 1;
          gnt_delay = {$random(seed)} % 3;
        end else if (dcache_req.data_req && gnt_delay > 0) begin
          gnt_delay--;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus tasks, each returns at the sample point of its last cycle
  // --------------------------------------------------------------------------
  task automatic issue_load(input ld_pkg::load_op_e op, input logic [2:0] off,
                            input logic [2:0] tid, input int hold_cycles,
                            input bit use_match, output int waited);
    logic [31:0] va;
    logic [31:0] pa;
    va = $random(seed);
    va[2:0] = off;
    pa = $random(seed);
    pa[11:0] = va[11:0];
    waited = 0;
    @(negedge clk_i);
    valid_i = 1'b1;
    ld_req.vaddr = va;
    ld_req.trans_id = tid;
    ld_req.operation = op;
    ld_req.be = 8'hff;
    paddr = pa;
    page_offset_matches_i = use_match;
    // nothing may go to the cache while the load is held back
    for (int c = 0; c < hold_cycles; c++) begin
      #40;
      check("data_req while held", 64'(0), 64'(dcache_req.data_req));
      check("pop_ld_o while held", 64'(0), 64'(pop_ld));
      if (c == hold_cycles - 1) hold_rsp = 1'b0;
      @(negedge clk_i);
    end
    page_offset_matches_i = 1'b0;
    #40;
    while (!pop_ld) begin
      check("pop_ld_o", 64'(dcache_req.data_req && dcache_rsp.data_gnt), 64'(pop_ld));
      waited++;
      if (waited > 50) begin
        $display("load was never accepted by the unit");
        $display("*** FAILED ***");
        $fatal(1, "no pop");
      end
      @(negedge clk_i);
      #40;
    end
    check("data_gnt at pop", 64'(1), 64'(dcache_rsp.data_gnt));
    // the index, the size and the store side offset all come from the load
    check("page_offset_o", 64'(va[11:0]), 64'(page_offset));
    check("address_index", 64'(va[11:0]), 64'(dcache_req.address_index));
    check("data_size", 64'(access_size(op)), 64'(dcache_req.data_size));
    check("data_be", 64'(8'hff), 64'(dcache_req.data_be));
    // paddr stays applied for the tag cycle
    @(negedge clk_i);
    valid_i = 1'b0;
    #40;
    check("tag_valid", 64'(1), 64'(dcache_req.tag_valid));
    check("address_tag", 64'(pa[31:12]), 64'(dcache_req.address_tag));
  endtask

  task automatic wait_drain();
    int count;
    count = 0;
    while (num_outstanding > 0 || pending.size() > 0 || tag_due) begin
      @(negedge clk_i);
      #40;
      count++;
      if (count > 500) begin
        $display("outstanding loads never drained in test %s", test_name);
        $display("*** FAILED ***");
        $fatal(1, "drain timeout");
      end
    end
  endtask

  task automatic sweep_ops_offsets();
    ld_pkg::load_op_e op;
    int max_off;
    int w;
    int n;
    test_name = "all_ops";
    n = 0;
    for (int o = 0; o < 7; o++) begin
      op = ld_pkg::load_op_e'(o);
      case (op)
        ld_pkg::LW, ld_pkg::LWU: max_off = 4;
        ld_pkg::LH, ld_pkg::LHU: max_off = 6;
        ld_pkg::LB, ld_pkg::LBU: max_off = 7;
        default:                 max_off = 0;
      endcase
      for (int off = 0; off <= max_off; off++) begin
        issue_load(op, 3'(off), 3'(n), 0, 1'b0, w);
        n++;
      end
    end
    wait_drain();
  endtask

  task automatic delay_grant();
    int w;
    test_name = "delayed_grant";
    force_delay = 2;
    issue_load(ld_pkg::LW, 3'd4, 3'd5, 0, 1'b0, w);
    check("grant wait cycles", 64'(2), 64'(w));
    wait_drain();
  endtask

  task automatic stall_on_page_match();
    int w;
    test_name = "page_match";
    issue_load(ld_pkg::LH, 3'd2, 3'd3, 4, 1'b1, w);
    wait_drain();
  endtask

  task automatic fill_buffer();
    int w;
    test_name = "full_buffer";
    hold_rsp = 1'b1;
    reverse_rsp = 1'b1;
    for (int i = 0; i < 4; i++) begin
      issue_load(ld_pkg::LB, 3'(i + 1), 3'(i), 0, 1'b0, w);
    end
    // the fifth load stalls until a held response frees a slot
    issue_load(ld_pkg::LD, 3'd0, 3'd7, 4, 1'b0, w);
    wait_drain();
    reverse_rsp = 1'b0;
  endtask

  task automatic flush_in_flight();
    int w;
    test_name = "flush";
    hold_rsp = 1'b1;
    issue_load(ld_pkg::LWU, 3'd0, 3'd1, 0, 1'b0, w);
    issue_load(ld_pkg::LBU, 3'd3, 3'd2, 0, 1'b0, w);
    @(negedge clk_i);
    flush_i = 1'b1;
    #40;
    // responses may return already in the cycle that kills the tag
    hold_rsp = 1'b0;
    @(negedge clk_i);
    flush_i = 1'b0;
    #40;
    check("kill_req after flush", 64'(1), 64'(dcache_req.kill_req));
    check("tag_valid after flush", 64'(1), 64'(dcache_req.tag_valid));
    wait_drain();
    issue_load(ld_pkg::LHU, 3'd6, 3'd4, 0, 1'b0, w);
    wait_drain();
  endtask

  initial begin : watchdog
    #(NUM_TESTS * 2000 * 100);
    $display("simulation timed out before all tests finished");
    $display("*** FAILED ***");
    $fatal(1, "watchdog");
  end

  initial begin : main
    rst_ni = 1'b0;
    flush_i = 1'b0;
    valid_i = 1'b0;
    page_offset_matches_i = 1'b0;
    ld_req = '0;
    paddr = '0;
    dcache_rsp = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    sweep_ops_offsets();
    delay_grant();
    stall_on_page_match();
    fill_buffer();
    flush_in_flight();
    if (error_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire

// ==== tb_load_unit_sva.sv ====
// ---------------------------------------------------------------------------
// load unit assertions: cache request strobes and response gating
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_load_unit_sva (
  input wire logic                clk_i,
  input wire logic                rst_ni,
  input wire logic                flush_i,
  input wire logic                pop_ld_o,
  input wire logic                valid_o,
  input wire ld_pkg::dcache_req_t dcache_req_o,
  input wire ld_pkg::dcache_rsp_t dcache_rsp_i
);

  // the tag always follows the accepted index by one cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ld_o |=> dcache_req_o.tag_valid)
    else $error("tag_valid missing one cycle after pop_ld_o");

  // a retired load needs a cache response in the same cycle, and every
  // load still in flight is marked flushed once the flush has passed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> dcache_rsp_i.data_rvalid && !$past(flush_i))
    else $error("valid_o without data_rvalid or right after a flush");

  // an ungranted request is held, only a flush may withdraw it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dcache_req_o.data_req && !dcache_rsp_i.data_gnt && !flush_i) |=> dcache_req_o.data_req)
    else $error("data_req dropped before data_gnt");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> dcache_req_o.kill_req)
    else $error("kill_req missing after flush_i");

endmodule

bind load_unit tb_load_unit_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .flush_i      (flush_i),
  .pop_ld_o     (pop_ld_o),
  .valid_o      (valid_o),
  .dcache_req_o (dcache_req_o),
  .dcache_rsp_i (dcache_rsp_i)
);

`default_nettype wire
